// File: Bender.yml
package:
  name: resp_buf

sources:
  - hdl/resp_types_pkg.sv
  - hdl/desc_pkg.sv
  - hdl/meta_queue.sv
  - hdl/merge_filter.sv
  - hdl/data_queue.sv
  - hdl/desc_tracker.sv
  - hdl/indirect_patch.sv
  - hdl/resp_buf_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/resp_buf_tb.sv

// File: hdl/data_queue.sv
`timescale 1ns/1ns
`default_nettype none

module data_queue
  import resp_types_pkg::*;
  import desc_pkg::*;
#(
  parameter int num_buffering = 8
) (
  input  wire logic              clk,
  input  wire logic              rst,
  input  wire logic              i_push,
  input  wire logic [data_w-1:0] i_data,
  input  wire logic              i_pop,
  output logic                   o_rdy,
  output desc_word_u             o_head_word
);

  localparam int ptr_w = $clog2(num_buffering);
  localparam logic [ptr_w-1:0] last_slot = ptr_w'(num_buffering - 1);
  localparam logic [ptr_w:0] rdy_limit = (ptr_w + 1)'(num_buffering - 2);

  logic [data_w-1:0] mem [num_buffering];
  logic [ptr_w-1:0]  wr_ptr;
  logic [ptr_w-1:0]  rd_ptr;
  logic [ptr_w-1:0]  rd_ptr_next;
  logic [ptr_w:0]    count;
  logic [ptr_w:0]    count_after_pop;

  // read pointer as it stands after this cycle's pop
  assign rd_ptr_next = !i_pop ? rd_ptr :
                       (rd_ptr == last_slot) ? '0 : rd_ptr + 1'b1;
  assign count_after_pop = count - {{ptr_w{1'b0}}, i_pop};

  // keep two slots spare for packets already in flight
  assign o_rdy = (count < rdy_limit);

  // zero while empty so no unwritten slot shows up at the output
  assign o_head_word.raw = (count_after_pop != '0) ? mem[rd_ptr_next] : '0;

  always_ff @(posedge clk) begin
    if (i_push) begin
      mem[wr_ptr] <= i_data;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (i_push) begin
        wr_ptr <= (wr_ptr == last_slot) ? '0 : wr_ptr + 1'b1;
      end
      rd_ptr <= rd_ptr_next;
      case ({i_push, i_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: hdl/desc_pkg.sv
`default_nettype none

package desc_pkg;

  // descriptor layout, word 7 down to word 0
  typedef struct packed {
    logic [31:0] opcode;
    logic [31:0] word6;
    logic [31:0] word5;
    logic [31:0] offset_c;
    logic [31:0] word3;
    logic [31:0] offset_ab;
    logic [31:0] addr_h;
    logic [31:0] addr_l;
  } desc_fields_t;

  // one data word, seen as raw data or as a descriptor
  typedef union packed {
    logic [255:0] raw;
    desc_fields_t desc;
  } desc_word_u;

  // read descriptor signature
  localparam logic [31:0] read_desc_addr_h = 32'h0000_0004;
  localparam logic [5:0]  mode_imm = 6'b000011;
  localparam logic [5:0]  mode_reg = 6'b000101;

  // addr_l marker bit, set on every read descriptor
  localparam int desc_mark_bit = 23;

  // expected descriptor address, addr_l[31:4]
  localparam logic [27:0] desc_start_addr = 28'h008_0000;
  localparam logic [27:0] desc_step = 28'd4;

  // mode bits in addr_l
  localparam int mode_indirect_bit = 0;
  localparam int mode_imm_bit = 1;
  localparam int mode_reg_bit = 2;

  // base register select in opcode
  localparam int opc_a_bit = 1;
  localparam int opc_b_bit = 2;
  localparam int opc_c_bit = 3;

endpackage

`default_nettype wire

// File: hdl/desc_tracker.sv
`timescale 1ns/1ns
`default_nettype none

module desc_tracker
  import desc_pkg::*;
(
  input  wire logic       clk,
  input  wire logic       rst,
  input  wire logic       i_clear,
  input  wire desc_word_u i_word,
  output logic            o_desc_enable
);

  logic [27:0] cur_addr;
  logic [27:0] next_addr;
  logic [27:0] word_addr;
  logic        is_read_desc;
  logic        hit_cur;
  logic        hit_next;

  assign word_addr = i_word.desc.addr_l[31:4];

  // read descriptor signature in addr_h and addr_l
  assign is_read_desc = (i_word.desc.addr_h == read_desc_addr_h) &&
                        ((i_word.desc.addr_l[5:0] == mode_imm) ||
                         (i_word.desc.addr_l[5:0] == mode_reg)) &&
                        i_word.desc.addr_l[desc_mark_bit] &&
                        (i_word.desc.addr_l[31:24] == 8'h00);

  assign hit_cur = is_read_desc && (word_addr == cur_addr);
  assign hit_next = is_read_desc && (word_addr == next_addr);
  assign o_desc_enable = hit_cur || hit_next;

  // a descriptor at the next address moves the window forward
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      cur_addr <= desc_start_addr;
      next_addr <= desc_start_addr + desc_step;
    end else if (i_clear) begin
      cur_addr <= desc_start_addr;
      next_addr <= desc_start_addr + desc_step;
    end else if (hit_next) begin
      cur_addr <= cur_addr + desc_step;
      next_addr <= next_addr + desc_step;
    end
  end

endmodule

`default_nettype wire

// File: hdl/indirect_patch.sv
`timescale 1ns/1ns
`default_nettype none

module indirect_patch
  import resp_types_pkg::*;
  import desc_pkg::*;
(
  input  wire logic       clk,
  input  wire logic       rst,
  input  wire desc_word_u i_word,
  input  wire logic       i_desc_enable,
  input  wire base_regs_t i_base_regs,
  output desc_word_u      o_data
);

  desc_fields_t d;
  desc_word_u   patched;
  logic         is_imm_indirect;
  logic         sel_a;
  logic         sel_b;
  logic         sel_c;

  assign d = i_word.desc;

  // register mode passes through untouched
  assign is_imm_indirect = i_desc_enable &&
                           d.addr_l[mode_indirect_bit] &&
                           d.addr_l[mode_imm_bit] &&
                           !d.addr_l[mode_reg_bit];

  assign sel_a = d.opcode[opc_a_bit];
  assign sel_b = d.opcode[opc_b_bit];
  assign sel_c = d.opcode[opc_c_bit];

  // A before B before C when several opcode bits are set
  always_comb begin
    patched = i_word;
    if (is_imm_indirect) begin
      if (sel_a) begin
        patched.desc.offset_ab = d.offset_ab + i_base_regs.a;
      end else if (sel_b) begin
        patched.desc.offset_ab = d.offset_ab + i_base_regs.b;
      end else if (sel_c) begin
        patched.desc.offset_c = d.offset_c + i_base_regs.c;
      end
    end
  end

  // single output stage
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      o_data <= '0;
    end else begin
      o_data <= patched;
    end
  end

endmodule

`default_nettype wire

// File: hdl/merge_filter.sv
`timescale 1ns/1ns
`default_nettype none

module merge_filter
  import resp_types_pkg::*;
(
  input  wire logic  clk,
  input  wire logic  rst,
  input  wire meta_t i_head,
  input  wire logic  i_head_valid,
  input  wire logic  i_nonempty,
  output logic       o_advance,
  output meta_t      o_pop_pkt,
  output logic       o_pop_valid
);

  // history: last emitted is o_pop_pkt, prev_pkt the one before
  meta_t prev_pkt;
  logic  last_valid;
  logic  prev_valid;
  logic  dup;
  logic  emit;

  // match against either of the two most recent emits
  assign dup = ((i_head == o_pop_pkt) && last_valid) ||
               ((i_head == prev_pkt) && prev_valid);
  assign emit = i_head_valid && !dup;

  // the head never waits, so pull whenever something is queued
  assign o_advance = i_nonempty;

  always_ff @(posedge clk) begin
    if (emit) begin
      o_pop_pkt <= i_head;
      prev_pkt <= o_pop_pkt;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      o_pop_valid <= 1'b0;
      last_valid <= 1'b0;
      prev_valid <= 1'b0;
    end else begin
      // merged heads drop here without touching the history
      o_pop_valid <= emit;
      if (emit) begin
        last_valid <= 1'b1;
        prev_valid <= last_valid;
      end
    end
  end

endmodule

`default_nettype wire

// File: hdl/meta_queue.sv
`timescale 1ns/1ns
`default_nettype none

module meta_queue
  import resp_types_pkg::*;
#(
  parameter int num_buffering = 8
) (
  input  wire logic  clk,
  input  wire logic  rst,
  input  wire logic  i_push,
  input  wire meta_t i_meta,
  input  wire logic  i_advance,
  output meta_t      o_head,
  output logic       o_head_valid,
  output logic       o_nonempty
);

  localparam int ptr_w = $clog2(num_buffering);
  localparam logic [ptr_w-1:0] last_slot = ptr_w'(num_buffering - 1);

  meta_t            mem [num_buffering];
  logic [ptr_w-1:0] ins_ptr;
  logic [ptr_w-1:0] pop_ptr;
  logic [ptr_w:0]   count;
  logic             pop;

  assign o_nonempty = (count != '0);
  // only take an entry when one is there
  assign pop = i_advance && o_nonempty;

  always_ff @(posedge clk) begin
    if (i_push) begin
      mem[ins_ptr] <= i_meta;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      ins_ptr <= '0;
      pop_ptr <= '0;
      count <= '0;
    end else begin
      if (i_push) begin
        ins_ptr <= (ins_ptr == last_slot) ? '0 : ins_ptr + 1'b1;
      end
      if (pop) begin
        pop_ptr <= (pop_ptr == last_slot) ? '0 : pop_ptr + 1'b1;
      end
      case ({i_push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // head register, oldest entry one cycle after advance
  always_ff @(posedge clk) begin
    if (pop) begin
      o_head <= mem[pop_ptr];
    end
  end

  // head is consumed by the filter in the cycle it is valid
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      o_head_valid <= 1'b0;
    end else begin
      o_head_valid <= pop;
    end
  end

endmodule

`default_nettype wire

// File: hdl/resp_buf_top.sv
`timescale 1ns/1ns
`default_nettype none

module resp_buf_top
  import resp_types_pkg::*;
  import desc_pkg::*;
#(
  parameter int num_buffering = 8
) (
  input  wire logic                 clk,
  input  wire logic                 rst,
  input  wire pkt_t                 i_pkt,
  input  wire rd_t                  i_rd_type,
  input  wire logic [ch_addr_w-1:0] i_ch_addr,
  input  wire logic                 i_pkt_valid,
  input  wire logic                 i_data_pop,
  input  wire base_regs_t           i_base_regs,
  input  wire logic                 i_hpc_clear,
  output logic                      o_rdy,
  output meta_t                     o_pop_pkt,
  output logic                      o_pop_valid,
  output desc_word_u                o_data
);

  logic       accept;
  meta_t      pkt_meta;
  meta_t      head;
  logic       head_valid;
  logic       nonempty;
  logic       advance;
  desc_word_u head_word;
  logic       desc_enable;

  // both queues take the packet in the same cycle
  assign accept = i_pkt_valid && o_rdy;

  assign pkt_meta = '{
    rd_type:  i_rd_type,
    ch_addr:  i_ch_addr,
    bk_addr:  i_pkt.bk_addr,
    row_addr: i_pkt.row_addr,
    col_addr: i_pkt.col_addr
  };

  meta_queue #(.num_buffering(num_buffering)) meta_queue_inst (
    .clk          (clk),
    .rst          (rst),
    .i_push       (accept),
    .i_meta       (pkt_meta),
    .i_advance    (advance),
    .o_head       (head),
    .o_head_valid (head_valid),
    .o_nonempty   (nonempty)
  );

  merge_filter merge_filter_inst (
    .clk          (clk),
    .rst          (rst),
    .i_head       (head),
    .i_head_valid (head_valid),
    .i_nonempty   (nonempty),
    .o_advance    (advance),
    .o_pop_pkt    (o_pop_pkt),
    .o_pop_valid  (o_pop_valid)
  );

  data_queue #(.num_buffering(num_buffering)) data_queue_inst (
    .clk         (clk),
    .rst         (rst),
    .i_push      (accept),
    .i_data      (i_pkt.data),
    .i_pop       (i_data_pop),
    .o_rdy       (o_rdy),
    .o_head_word (head_word)
  );

  desc_tracker desc_tracker_inst (
    .clk           (clk),
    .rst           (rst),
    .i_clear       (i_hpc_clear),
    .i_word        (head_word),
    .o_desc_enable (desc_enable)
  );

  indirect_patch indirect_patch_inst (
    .clk           (clk),
    .rst           (rst),
    .i_word        (head_word),
    .i_desc_enable (desc_enable),
    .i_base_regs   (i_base_regs),
    .o_data        (o_data)
  );

endmodule

`default_nettype wire

// File: hdl/resp_types_pkg.sv
`default_nettype none

package resp_types_pkg;

  localparam int ch_addr_w = 3;
  localparam int data_w = 256;

  // read response class, carried with the metadata
  typedef enum logic [1:0] {
    rd_data     = 2'b00,
    rd_desc     = 2'b01,
    rd_prefetch = 2'b10,
    rd_other    = 2'b11
  } rd_t;

  // packet as delivered by the interconnect
  typedef struct packed {
    logic [3:0]        bk_addr;
    logic [13:0]       row_addr;
    logic [5:0]        col_addr;
    logic [data_w-1:0] data;
  } pkt_t;

  // metadata kept per packet, also the emitted packet
  typedef struct packed {
    rd_t                  rd_type;
    logic [ch_addr_w-1:0] ch_addr;
    logic [3:0]           bk_addr;
    logic [13:0]          row_addr;
    logic [5:0]           col_addr;
  } meta_t;

  // base registers for indirect addressing
  typedef struct packed {
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
  } base_regs_t;

endpackage

`default_nettype wire

// File: src.f
+incdir+include
hdl/resp_types_pkg.sv
hdl/desc_pkg.sv
hdl/meta_queue.sv
hdl/merge_filter.sv
hdl/data_queue.sv
hdl/desc_tracker.sv
hdl/indirect_patch.sv
hdl/resp_buf_top.sv
testbench/resp_buf_tb.sv

// File: include/resp_buf_tb_checks.svh
`ifndef RESP_BUF_TB_CHECKS_SVH
`define RESP_BUF_TB_CHECKS_SVH

// running totals over all compares
int pass_count = 0;
int fail_count = 0;

task automatic check_meta(input resp_types_pkg::meta_t got,
                          input resp_types_pkg::meta_t exp,
                          input string msg);
  if (got === exp) begin
    pass_count++;
  end else begin
    fail_count++;
    $display("CHECK FAILED at %0t: %s got %h expected %h", $time, msg, got, exp);
  end
endtask

task automatic check_word(input desc_pkg::desc_word_u got,
                          input desc_pkg::desc_word_u exp,
                          input string msg);
  if (got.raw === exp.raw) begin
    pass_count++;
  end else begin
    fail_count++;
    $display("CHECK FAILED at %0t: %s", $time, msg);
    $display("  got      %h", got.raw);
    $display("  expected %h", exp.raw);
  end
endtask

task automatic check_bit(input logic got, input logic exp, input string msg);
  if (got === exp) begin
    pass_count++;
  end else begin
    fail_count++;
    $display("CHECK FAILED at %0t: %s got %b expected %b", $time, msg, got, exp);
  end
endtask

`endif

// File: testbench/resp_buf_tb.sv
`timescale 1ns/1ns
`default_nettype none

module resp_buf_tb
  import resp_types_pkg::*;
  import desc_pkg::*;
();

  localparam int num_buffering = 8;
  localparam int reset_cycles = 16;
  localparam int cycles_per_line = 20;
  localparam data_path = "testbench/resp_buf_testdata.txt";

  logic                 clk = 1'b0;
  logic                 rst;
  pkt_t                 i_pkt;
  rd_t                  i_rd_type;
  logic [ch_addr_w-1:0] i_ch_addr;
  logic                 i_pkt_valid;
  logic                 i_data_pop;
  base_regs_t           i_base_regs;
  logic                 i_hpc_clear;
  logic                 o_rdy;
  meta_t                o_pop_pkt;
  logic                 o_pop_valid;
  desc_word_u           o_data;

  `include "resp_buf_tb_checks.svh"

  // expected emits, plus the model's two-deep emit history
  meta_t exp_q [$];
  meta_t exp_pkt;
  meta_t hist_last;
  meta_t hist_prev;
  logic  hist_last_ok = 1'b0;
  logic  hist_prev_ok = 1'b0;

  // words the data queue should hold
  int    data_count = 0;

  int    fd;
  int    cycle_count = 0;
  int    cycle_limit = 0;
  string test_name = "";
  int    test_fail_base = 0;

  resp_buf_top #(.num_buffering(num_buffering)) resp_buf_top_inst (
    .clk         (clk),
    .rst         (rst),
    .i_pkt       (i_pkt),
    .i_rd_type   (i_rd_type),
    .i_ch_addr   (i_ch_addr),
    .i_pkt_valid (i_pkt_valid),
    .i_data_pop  (i_data_pop),
    .i_base_regs (i_base_regs),
    .i_hpc_clear (i_hpc_clear),
    .o_rdy       (o_rdy),
    .o_pop_pkt   (o_pop_pkt),
    .o_pop_valid (o_pop_valid),
    .o_data      (o_data)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > cycle_limit) begin
      $display("timeout after %0d cycles, the test sequence did not complete", cycle_count);
      $display("Verification failed");
      $finish;
    end
  end

  // every emit must match the oldest expected packet
  always @(negedge clk) begin
    if (!rst && o_pop_valid) begin
      if (exp_q.size() == 0) begin
        fail_count++;
        $display("unexpected packet emitted at %0t: %h", $time, o_pop_pkt);
      end else begin
        exp_pkt = exp_q.pop_front();
        check_meta(o_pop_pkt, exp_pkt, "emitted packet");
      end
    end
  end

  function automatic int count_lines();
    int    cfd;
    int    n;
    string line;
    n = 0;
    cfd = $fopen(data_path, "r");
    if (cfd != 0) begin
      while ($fgets(line, cfd) > 0) begin
        n++;
      end
      $fclose(cfd);
    end
    return n;
  endfunction

  // fields 5 to 12 hold word 7 down to word 0
  function automatic desc_word_u words_to_data(input logic [31:0] f [13]);
    desc_word_u w;
    w.raw = {f[5], f[6], f[7], f[8], f[9], f[10], f[11], f[12]};
    return w;
  endfunction

  // a packet equal to one of the last two emits is merged away
  task automatic expect_packet(input meta_t m);
    if ((hist_last_ok && m == hist_last) || (hist_prev_ok && m == hist_prev)) begin
      $display("  packet row %h merged", m.row_addr);
    end else begin
      exp_q.push_back(m);
      hist_prev = hist_last;
      hist_prev_ok = hist_last_ok;
      hist_last = m;
      hist_last_ok = 1'b1;
    end
  endtask

  task automatic send_packet(input logic [31:0] f [13]);
    meta_t      m;
    desc_word_u w;
    logic       exp_rdy;
    m.rd_type = rd_t'(f[0][1:0]);
    m.ch_addr = f[1][ch_addr_w-1:0];
    m.bk_addr = f[2][3:0];
    m.row_addr = f[3][13:0];
    m.col_addr = f[4][5:0];
    w = words_to_data(f);
    // room only while fewer than num_buffering-2 words are stored
    exp_rdy = (data_count < num_buffering - 2);
    @(negedge clk);
    i_rd_type = m.rd_type;
    i_ch_addr = m.ch_addr;
    i_pkt.bk_addr = m.bk_addr;
    i_pkt.row_addr = m.row_addr;
    i_pkt.col_addr = m.col_addr;
    i_pkt.data = w.raw;
    i_pkt_valid = 1'b1;
    check_bit(o_rdy, exp_rdy, "o_rdy at push");
    @(posedge clk);
    if (exp_rdy) begin
      data_count++;
      expect_packet(m);
    end
    @(negedge clk);
    i_pkt_valid = 1'b0;
  endtask

  task automatic pop_data(input desc_word_u exp);
    data_count--;
    @(negedge clk);
    i_data_pop = 1'b1;
    @(negedge clk);
    i_data_pop = 1'b0;
    check_word(o_data, exp, "o_data after pop");
  endtask

  task automatic pulse_clear();
    @(negedge clk);
    i_hpc_clear = 1'b1;
    @(negedge clk);
    i_hpc_clear = 1'b0;
  endtask

  task automatic close_test();
    while (exp_q.size() != 0) begin
      @(negedge clk);
    end
    repeat (4) @(negedge clk);
    if (fail_count == test_fail_base) begin
      $display("test %s: ok", test_name);
    end else begin
      $display("test %s: %0d errors", test_name, fail_count - test_fail_base);
    end
    test_fail_base = fail_count;
  endtask

  task automatic run_file(input int rfd);
    string       line;
    string       op;
    string       what;
    logic [31:0] f [13];
    desc_word_u  w;
    int          n;
    while ($fgets(line, rfd) > 0) begin
      op = "";
      n = $sscanf(line, "%s", op);
      if (n < 1 || op.getc(0) == "#") begin
        continue;
      end
      if (op == "test") begin
        if (test_name != "") begin
          close_test();
        end
        n = $sscanf(line, "%s %s", op, test_name);
      end else if (op == "base") begin
        n = $sscanf(line, "%s %h %h %h", op, f[0], f[1], f[2]);
        @(negedge clk);
        i_base_regs.a = f[0];
        i_base_regs.b = f[1];
        i_base_regs.c = f[2];
      end else if (op == "push") begin
        n = $sscanf(line, "%s %d %d %h %h %h %h %h %h %h %h %h %h %h", op, f[0], f[1], f[2],
                    f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11], f[12]);
        send_packet(f);
      end else if (op == "pop") begin
        n = $sscanf(line, "%s %h %h %h %h %h %h %h %h", op, f[5], f[6], f[7], f[8], f[9],
                    f[10], f[11], f[12]);
        w = words_to_data(f);
        pop_data(w);
      end else if (op == "clear") begin
        pulse_clear();
      end else if (op == "check") begin
        n = $sscanf(line, "%s %s %h %h %h %h %h %h %h %h", op, what, f[5], f[6], f[7], f[8],
                    f[9], f[10], f[11], f[12]);
        @(negedge clk);
        w = words_to_data(f);
        if (what == "rdy") begin
          check_bit(o_rdy, f[5][0], "o_rdy");
        end else if (what == "valid") begin
          check_bit(o_pop_valid, f[5][0], "o_pop_valid");
        end else if (what == "data") begin
          check_word(o_data, w, "o_data");
        end else begin
          fail_count++;
          $display("unknown check '%s' in the stimulus file", what);
        end
      end else begin
        fail_count++;
        $display("unknown operation '%s' in the stimulus file", op);
      end
    end
    if (test_name != "") begin
      close_test();
    end
  endtask

  initial begin
    rst = 1'b1;
    i_pkt = '0;
    i_rd_type = rd_data;
    i_ch_addr = '0;
    i_pkt_valid = 1'b0;
    i_data_pop = 1'b0;
    i_base_regs = '0;
    i_hpc_clear = 1'b0;
    cycle_limit = cycles_per_line * count_lines() + reset_cycles;
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    fd = $fopen(data_path, "r");
    if (fd == 0) begin
      fail_count++;
      $display("could not open the stimulus file %s", data_path);
    end else begin
      run_file(fd);
      $fclose(fd);
    end
    $display("%0d checks passed, %0d checks failed", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: testbench/resp_buf_testdata.txt
# push rd ch bk row col w7..w0 | pop w7..w0 (o_data after the pop) | check rdy|valid bit
# check data w7..w0 | base a b c | clear | test name (words in hex, word 0 is addr_l)
test reset
check valid 0
check rdy 1
check data 0 0 0 0 0 0 0 0
base 00001000 00002000 00003000
test order
push 0 1 2 0010 03 a0000007 a0000006 a0000005 a0000004 a0000003 a0000002 a0000001 a0000000
push 0 1 2 0011 03 b0000007 b0000006 b0000005 b0000004 b0000003 b0000002 b0000001 b0000000
push 0 1 2 0012 03 c0000007 c0000006 c0000005 c0000004 c0000003 c0000002 c0000001 c0000000
check data a0000007 a0000006 a0000005 a0000004 a0000003 a0000002 a0000001 a0000000
pop b0000007 b0000006 b0000005 b0000004 b0000003 b0000002 b0000001 b0000000
pop c0000007 c0000006 c0000005 c0000004 c0000003 c0000002 c0000001 c0000000
pop 0 0 0 0 0 0 0 0
test merge
push 0 1 2 0012 03 0 0 0 0 0 0 0 1
push 0 1 2 0011 03 0 0 0 0 0 0 0 2
push 0 1 2 0010 03 0 0 0 0 0 0 0 3
push 0 1 2 0012 03 0 0 0 0 0 0 0 4
push 0 1 2 0011 03 0 0 0 0 0 0 0 5
check data 0 0 0 0 0 0 0 1
pop 0 0 0 0 0 0 0 2
pop 0 0 0 0 0 0 0 3
pop 0 0 0 0 0 0 0 4
pop 0 0 0 0 0 0 0 5
pop 0 0 0 0 0 0 0 0
test backpressure
push 0 2 5 0020 07 0 0 0 0 0 0 0 21
push 0 2 5 0021 07 0 0 0 0 0 0 0 22
push 0 2 5 0022 07 0 0 0 0 0 0 0 23
push 0 2 5 0023 07 0 0 0 0 0 0 0 24
push 0 2 5 0024 07 0 0 0 0 0 0 0 25
push 0 2 5 0025 07 0 0 0 0 0 0 0 26
check rdy 0
push 0 2 5 0026 07 0 0 0 0 0 0 0 27
pop 0 0 0 0 0 0 0 22
check rdy 1
pop 0 0 0 0 0 0 0 23
pop 0 0 0 0 0 0 0 24
pop 0 0 0 0 0 0 0 25
pop 0 0 0 0 0 0 0 26
pop 0 0 0 0 0 0 0 0
test descriptor
push 1 3 1 0030 00 00000002 0 0 00000020 0 00000010 00000004 00800003
push 1 3 1 0031 00 00000008 0 0 00000020 0 00000010 00000004 00800043
push 1 3 1 0032 00 00000002 0 0 00000020 0 00000010 00000004 00900003
push 1 3 1 0033 00 00000002 0 0 00000020 0 00000010 00000004 00800045
check data 00000002 0 0 00000020 0 00001010 00000004 00800003
pop 00000008 0 0 00003020 0 00000010 00000004 00800043
pop 00000002 0 0 00000020 0 00000010 00000004 00900003
pop 00000002 0 0 00000020 0 00000010 00000004 00800045
pop 0 0 0 0 0 0 0 0
test clear
push 1 3 1 0040 00 00000002 0 0 00000020 0 00000010 00000004 00800003
check data 00000002 0 0 00000020 0 00000010 00000004 00800003
clear
check data 00000002 0 0 00000020 0 00001010 00000004 00800003
push 1 3 1 0041 00 00000004 0 0 00000020 0 00000010 00000004 00800043
pop 00000004 0 0 00000020 0 00002010 00000004 00800043
pop 0 0 0 0 0 0 0 0
